// ==== vlog.f ====
spw_tx_pkg.sv
spw_char_serializer.sv
spw_flow_credit.sv
spw_link_fsm.sv
spw_tx_top.sv
tb_spw_ds_decoder.sv
tb_spw_tx.sv

// ==== tb_spw_tx.sv ====
// Testbench for the SpaceWire link transmitter.
// Walks the link through start, null, null-and-FCT and run, sends data,
// EOP, EEP, time codes and owed FCTs, and checks the decoded line with
// concurrent assertions against a scoreboard of expected characters.

module tb_spw_tx;

	timeunit 1ns;
	timeprecision 1ns;

	localparam int  INIT_FCT    = 7;
	localparam int  PERIOD      = 40;
	localparam int  STIM_CHARS  = 400;
	localparam time WATCHDOG_NS = STIM_CHARS * spw_tx_pkg::LEN_TIMECODE * PERIOD + 4000;

	logic                      pclk_tx = 1'b0;
	logic                      enable_tx;
	logic                      send_null_tx_i;
	logic                      send_fct_tx_i;
	logic                      got_fct_i;
	logic                      fct_req_i;
	spw_tx_pkg::spw_nchar_t    data_i;
	logic                      txwrite_i;
	spw_tx_pkg::spw_timecode_t timecode_i;
	logic                      tick_i;
	logic                      tx_dout_o;
	logic                      tx_sout_o;
	logic                      ready_data_o;
	logic                      ready_timecode_o;

	logic                       dec_valid;
	spw_tx_pkg::spw_char_kind_e dec_kind;
	spw_tx_pkg::spw_nchar_t     dec_value;
	logic                       dec_parity_err;
	logic                       dec_seq_err;

	// Scoreboard
	spw_tx_pkg::spw_nchar_t    nchar_q[$];
	spw_tx_pkg::spw_timecode_t tc_q[$];
	spw_tx_pkg::spw_nchar_t    nchar_exp;
	spw_tx_pkg::spw_timecode_t tc_exp;
	logic nchar_have;
	logic tc_have;
	logic fct_have;
	logic fct_phase;
	logic tc_first;
	logic tc_first_chk;
	logic line_active;
	int   exp_fct;
	int   grants;
	int   presented_nchar;
	int   presented_tc;
	int   ready_data_cnt;
	int   ready_tc_cnt;
	int   value_errors;
	int   protocol_errors;

	always #(PERIOD / 2) pclk_tx = ~pclk_tx;

	spw_tx_top #(
		.INIT_FCT_COUNT (INIT_FCT)
	) dut_i (
		.pclk_tx          (pclk_tx),
		.enable_tx        (enable_tx),
		.send_null_tx_i   (send_null_tx_i),
		.send_fct_tx_i    (send_fct_tx_i),
		.got_fct_i        (got_fct_i),
		.fct_req_i        (fct_req_i),
		.data_i           (data_i),
		.txwrite_i        (txwrite_i),
		.timecode_i       (timecode_i),
		.tick_i           (tick_i),
		.tx_dout_o        (tx_dout_o),
		.tx_sout_o        (tx_sout_o),
		.ready_data_o     (ready_data_o),
		.ready_timecode_o (ready_timecode_o)
	);

	tb_spw_ds_decoder u_decoder (
		.pclk_tx      (pclk_tx),
		.enable_tx    (enable_tx),
		.d_i          (tx_dout_o),
		.s_i          (tx_sout_o),
		.char_valid_o (dec_valid),
		.kind_o       (dec_kind),
		.value_o      (dec_value),
		.parity_err_o (dec_parity_err),
		.seq_err_o    (dec_seq_err)
	);

	//--------------------------------------------------------------------------
	// Expected character lookup, between the decoder's edges
	//--------------------------------------------------------------------------
	always @(negedge pclk_tx)
	begin
		tc_first_chk = 1'b0;
		if (dec_valid)
		begin
			case (dec_kind)
				spw_tx_pkg::CHAR_NCHAR:
				begin
					nchar_have = (nchar_q.size() != 0);
					nchar_exp  = nchar_have ? nchar_q.pop_front() : '0;
				end
				spw_tx_pkg::CHAR_TIMECODE:
				begin
					tc_have = (tc_q.size() != 0);
					tc_exp  = tc_have ? tc_q.pop_front() : '0;
				end
				spw_tx_pkg::CHAR_FCT:
				begin
					fct_have = (exp_fct > 0);
					if (fct_have)
					begin
						exp_fct = exp_fct - 1;
					end
				end
				default:
				begin
				end
			endcase
			if (dec_kind != spw_tx_pkg::CHAR_NULL)
			begin
				tc_first_chk = tc_first;
				tc_first     = 1'b0;
			end
		end
	end

	always @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			ready_data_cnt <= 0;
			ready_tc_cnt   <= 0;
			line_active    <= 1'b0;
		end
		else
		begin
			ready_data_cnt <= ready_data_cnt + int'(ready_data_o);
			ready_tc_cnt   <= ready_tc_cnt + int'(ready_timecode_o);
			if (tx_dout_o || tx_sout_o)
			begin
				line_active <= 1'b1;
			end
		end
	end

	//--------------------------------------------------------------------------
	// Checks
	//--------------------------------------------------------------------------
	a_idle_before_null: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		!send_null_tx_i |-> !(tx_dout_o || tx_sout_o || ready_data_o || ready_timecode_o))
	else
	begin
		protocol_errors++;
		$display("Output activity at %0t before send_null_tx_i was raised", $time);
	end

	a_null_only: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		(dec_valid && !fct_phase) |-> dec_kind == spw_tx_pkg::CHAR_NULL)
	else
	begin
		protocol_errors++;
		$display("Error %0t: dec_kind got %0d expected NULL", $time, $sampled(dec_kind));
	end

	a_fct_expected: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		(dec_valid && dec_kind == spw_tx_pkg::CHAR_FCT) |-> fct_have)
	else
	begin
		protocol_errors++;
		$display("Unexpected FCT on the line at %0t", $time);
	end

	a_nchar_value: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		(dec_valid && dec_kind == spw_tx_pkg::CHAR_NCHAR)
		|-> nchar_have && dec_value == nchar_exp)
	else
	begin
		value_errors++;
		$display("Error %0t: dec_value got %h expected %h", $time, $sampled(dec_value),
			$sampled(nchar_exp));
	end

	a_tc_value: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		(dec_valid && dec_kind == spw_tx_pkg::CHAR_TIMECODE)
		|-> tc_have && dec_value[7:0] == tc_exp)
	else
	begin
		value_errors++;
		$display("Error %0t: timecode got %h expected %h", $time, $sampled(dec_value[7:0]),
			$sampled(tc_exp));
	end

	a_tc_first: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		(dec_valid && tc_first_chk) |-> dec_kind == spw_tx_pkg::CHAR_TIMECODE)
	else
	begin
		protocol_errors++;
		$display("Time code was not sent ahead of pending FCT and data at %0t", $time);
	end

	// Credit bound also rules out data before the first grant
	a_credit_bound: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		ready_data_o |-> ready_data_cnt < grants * int'(spw_tx_pkg::CREDIT_PER_FCT))
	else
	begin
		protocol_errors++;
		$display("N-char accepted at %0t beyond the credit granted", $time);
	end

	a_ready_data: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		ready_data_o |-> txwrite_i ##1 !ready_data_o)
	else
	begin
		protocol_errors++;
		$display("ready_data_o pulse at %0t without request or longer than one cycle", $time);
	end

	a_ready_tc: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		ready_timecode_o |-> tick_i ##1 !ready_timecode_o)
	else
	begin
		protocol_errors++;
		$display("ready_timecode_o pulse at %0t without tick or too long", $time);
	end

	a_parity: assert property (@(posedge pclk_tx) disable iff (!enable_tx) !dec_parity_err)
	else
	begin
		protocol_errors++;
		$display("Parity bit wrong in character decoded at %0t", $time);
	end

	a_escape: assert property (@(posedge pclk_tx) disable iff (!enable_tx) !dec_seq_err)
	else
	begin
		protocol_errors++;
		$display("ESC followed by a control character other than FCT at %0t", $time);
	end

	a_ds_rule: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		line_active |-> $changed(tx_dout_o) != $changed(tx_sout_o))
	else
	begin
		protocol_errors++;
		$display("DS rule broken at %0t, not exactly one line changed", $time);
	end

	//--------------------------------------------------------------------------
	// Stimulus tasks, all entered on a falling edge
	//--------------------------------------------------------------------------
	task automatic wait_cycles(input int n);
		repeat (n) @(negedge pclk_tx);
	endtask

	task automatic send_nchar(input spw_tx_pkg::spw_nchar_t v);
		nchar_q.push_back(v);
		presented_nchar++;
		data_i    = v;
		txwrite_i = 1'b1;
		#1;
		while (!ready_data_o)
		begin
			@(negedge pclk_tx);
			#1;
		end
		@(negedge pclk_tx);
		txwrite_i = 1'b0;
	endtask

	task automatic send_timecode(input spw_tx_pkg::spw_timecode_t v);
		tc_q.push_back(v);
		presented_tc++;
		timecode_i = v;
		tick_i     = 1'b1;
		#1;
		while (!ready_timecode_o)
		begin
			@(negedge pclk_tx);
			#1;
		end
		@(negedge pclk_tx);
		tick_i = 1'b0;
	endtask

	task automatic grant_credit();
		got_fct_i = 1'b1;
		grants++;
		@(negedge pclk_tx);
		got_fct_i = 1'b0;
	endtask

	task automatic request_fct();
		fct_req_i = 1'b1;
		exp_fct++;
		@(negedge pclk_tx);
		fct_req_i = 1'b0;
	endtask

	task automatic wait_drained();
		while (nchar_q.size() != 0 || tc_q.size() != 0 || exp_fct != 0)
		begin
			@(negedge pclk_tx);
		end
	endtask

	// Mostly data bytes, now and then EOP or EEP
	function automatic spw_tx_pkg::spw_nchar_t random_nchar();
		int r;
		r = $urandom_range(0, 9);
		if (r == 0)
		begin
			return 9'h100;
		end
		if (r == 1)
		begin
			return 9'h101;
		end
		return {1'b0, 8'($urandom)};
	endfunction

	//--------------------------------------------------------------------------
	// Main sequence
	//--------------------------------------------------------------------------
	initial
	begin
		void'($urandom(32'hcffea5b5));
		enable_tx       = 1'b0;
		send_null_tx_i  = 1'b0;
		send_fct_tx_i   = 1'b0;
		got_fct_i       = 1'b0;
		fct_req_i       = 1'b0;
		data_i          = '0;
		txwrite_i       = 1'b0;
		timecode_i      = '0;
		tick_i          = 1'b0;
		fct_phase       = 1'b0;
		tc_first        = 1'b0;
		tc_first_chk    = 1'b0;
		nchar_have      = 1'b0;
		tc_have         = 1'b0;
		fct_have        = 1'b0;
		exp_fct         = 0;
		grants          = 0;
		presented_nchar = 0;
		presented_tc    = 0;
		value_errors    = 0;
		protocol_errors = 0;
		repeat (4) @(negedge pclk_tx);
		enable_tx = 1'b1;

		// Start state, then NULLs only
		wait_cycles(20);
		send_null_tx_i = 1'b1;
		wait_cycles(20 * spw_tx_pkg::LEN_NULL);

		// Initial FCTs, a data request held with no credit yet
		fct_phase     = 1'b1;
		exp_fct       = exp_fct + INIT_FCT;
		send_fct_tx_i = 1'b1;
		fork
			send_nchar(random_nchar());
			begin
				while (exp_fct != 0)
				begin
					@(negedge pclk_tx);
				end
				wait_cycles(10 * spw_tx_pkg::LEN_NULL);
				grant_credit();
			end
		join

		// Data in batches of one credit grant each
		for (int b = 0; b < 3; b++)
		begin
			grant_credit();
			for (int i = 0; i < 8; i++)
			begin
				wait_cycles($urandom_range(0, 20));
				send_nchar(random_nchar());
			end
		end

		// Owed FCTs in run state
		for (int i = 0; i < 3; i++)
		begin
			request_fct();
			wait_cycles($urandom_range(5, 30));
		end
		wait_drained();
		wait_cycles(20);

		// Tick, owed FCT and data all at one boundary
		tc_first = 1'b1;
		fork
			send_timecode(8'($urandom));
			send_nchar(random_nchar());
			request_fct();
		join
		for (int i = 0; i < 3; i++)
		begin
			wait_cycles($urandom_range(0, 20));
			send_timecode(8'($urandom));
		end
		wait_drained();
		wait_cycles(40);

		assert (ready_data_cnt == presented_nchar)
		else
		begin
			protocol_errors++;
			$display("Error %0t: ready_data_o pulses got %0d expected %0d", $time,
				ready_data_cnt, presented_nchar);
		end
		assert (ready_tc_cnt == presented_tc)
		else
		begin
			protocol_errors++;
			$display("Error %0t: ready_timecode_o pulses got %0d expected %0d", $time,
				ready_tc_cnt, presented_tc);
		end

		$display("Value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the stimulus did not complete in time");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== tb_spw_ds_decoder.sv ====
// Testbench model of a SpaceWire receiver front end.
// Recovers bits from the DS pair on each rising pclk_tx edge, rebuilds
// characters and checks the parity bit. Each decoded character is
// published with a one-cycle char_valid_o pulse.

module tb_spw_ds_decoder (
	input  logic                       pclk_tx,
	input  logic                       enable_tx,
	input  logic                       d_i,
	input  logic                       s_i,
	output logic                       char_valid_o,
	output spw_tx_pkg::spw_char_kind_e kind_o,
	output spw_tx_pkg::spw_nchar_t     value_o,
	output logic                       parity_err_o,
	output logic                       seq_err_o
);

	timeunit 1ns;
	timeprecision 1ns;

	logic       d_q;
	logic       s_q;
	logic [9:0] word_q;
	logic [9:0] word;
	logic [3:0] pos_q;
	logic [3:0] len;
	logic [1:0] code;
	logic       esc_q;
	logic       prev_par_q;

	always @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			d_q          <= 1'b0;
			s_q          <= 1'b0;
			word_q       <= '0;
			pos_q        <= '0;
			esc_q        <= 1'b0;
			prev_par_q   <= 1'b0;
			char_valid_o <= 1'b0;
			kind_o       <= spw_tx_pkg::CHAR_NULL;
			value_o      <= '0;
			parity_err_o <= 1'b0;
			seq_err_o    <= 1'b0;
		end
		else
		begin
			char_valid_o <= 1'b0;
			parity_err_o <= 1'b0;
			seq_err_o    <= 1'b0;
			d_q          <= d_i;
			s_q          <= s_i;

			// Any change on the pair carries one bit, the data line value
			if ({d_i, s_i} != {d_q, s_q})
			begin
				word        = word_q;
				word[pos_q] = d_i;
				len         = (pos_q >= 4'd1 && word[1]) ? 4'd4 : 4'd10;
				if (pos_q == len - 4'd1)
				begin
					pos_q <= '0;
					if (word[0] != ~(prev_par_q ^ word[1]))
					begin
						parity_err_o <= 1'b1;
					end
					if (word[1])
					begin
						code       = word[3:2];
						prev_par_q <= ^code;
						if (esc_q)
						begin
							// ESC may only be followed by FCT here
							esc_q <= 1'b0;
							if (code == spw_tx_pkg::CTRL_FCT)
							begin
								char_valid_o <= 1'b1;
								kind_o       <= spw_tx_pkg::CHAR_NULL;
							end
							else
							begin
								seq_err_o <= 1'b1;
							end
						end
						else if (code == spw_tx_pkg::CTRL_ESC)
						begin
							esc_q <= 1'b1;
						end
						else
						begin
							char_valid_o <= 1'b1;
							if (code == spw_tx_pkg::CTRL_FCT)
							begin
								kind_o <= spw_tx_pkg::CHAR_FCT;
							end
							else
							begin
								kind_o  <= spw_tx_pkg::CHAR_NCHAR;
								value_o <= (code == spw_tx_pkg::CTRL_EEP) ? 9'h101 : 9'h100;
							end
						end
					end
					else
					begin
						prev_par_q   <= ^word[9:2];
						char_valid_o <= 1'b1;
						value_o      <= {1'b0, word[9:2]};
						kind_o       <= esc_q ? spw_tx_pkg::CHAR_TIMECODE
						                      : spw_tx_pkg::CHAR_NCHAR;
						esc_q        <= 1'b0;
					end
				end
				else
				begin
					pos_q <= pos_q + 4'd1;
				end
				word_q <= word;
			end
		end
	end

endmodule

// ==== spw_tx_top.sv ====
// SpaceWire link transmitter, top level.
// Connects the link FSM, the flow-credit counters and the character
// serializer. The DS pair leaves on tx_dout_o / tx_sout_o, one bit per
// pclk_tx cycle. Producers hold txwrite_i or tick_i until the ready pulse.

module spw_tx_top #(
	parameter int INIT_FCT_COUNT = 7
) (
	input  logic                      pclk_tx,
	input  logic                      enable_tx,

	// Link control from the link interface
	input  logic                      send_null_tx_i,
	input  logic                      send_fct_tx_i,

	// Flow control pulses
	input  logic                      got_fct_i,
	input  logic                      fct_req_i,

	// N-char request
	input  spw_tx_pkg::spw_nchar_t    data_i,
	input  logic                      txwrite_i,

	// Time-code request
	input  spw_tx_pkg::spw_timecode_t timecode_i,
	input  logic                      tick_i,

	output logic                      tx_dout_o,
	output logic                      tx_sout_o,
	output logic                      ready_data_o,
	output logic                      ready_timecode_o
);

	logic                       load;
	spw_tx_pkg::spw_char_kind_e char_kind;
	logic                       char_done;
	logic                       nchar_sent;
	logic                       fct_sent;
	logic                       credit_avail;
	logic                       fct_pending;

	spw_link_fsm #(
		.INIT_FCT_COUNT (INIT_FCT_COUNT)
	) u_link_fsm (
		.pclk_tx          (pclk_tx),
		.enable_tx        (enable_tx),
		.send_null_tx_i   (send_null_tx_i),
		.send_fct_tx_i    (send_fct_tx_i),
		.txwrite_i        (txwrite_i),
		.tick_i           (tick_i),
		.char_done_i      (char_done),
		.credit_avail_i   (credit_avail),
		.fct_pending_i    (fct_pending),
		.load_o           (load),
		.char_kind_o      (char_kind),
		.nchar_sent_o     (nchar_sent),
		.fct_sent_o       (fct_sent),
		.ready_data_o     (ready_data_o),
		.ready_timecode_o (ready_timecode_o)
	);

	// Credit and owed-FCT bookkeeping beside the FSM
	spw_flow_credit u_flow_credit (
		.pclk_tx        (pclk_tx),
		.enable_tx      (enable_tx),
		.got_fct_i      (got_fct_i),
		.fct_req_i      (fct_req_i),
		.nchar_sent_i   (nchar_sent),
		.fct_sent_i     (fct_sent),
		.credit_avail_o (credit_avail),
		.fct_pending_o  (fct_pending)
	);

	spw_char_serializer u_char_serializer (
		.pclk_tx     (pclk_tx),
		.enable_tx   (enable_tx),
		.load_i      (load),
		.char_kind_i (char_kind),
		.data_i      (data_i),
		.timecode_i  (timecode_i),
		.char_done_o (char_done),
		.tx_dout_o   (tx_dout_o),
		.tx_sout_o   (tx_sout_o)
	);

endmodule

// ==== spw_link_fsm.sv ====
// Link state machine of the transmitter.
// Walks start, null, null-and-FCT and run, and at each character boundary
// picks the next character kind. Loads coincide with char_done_i so the
// serializer sends characters back to back.

module spw_link_fsm #(
	parameter int INIT_FCT_COUNT = 7
) (
	input  logic                       pclk_tx,
	input  logic                       enable_tx,
	input  logic                       send_null_tx_i,
	input  logic                       send_fct_tx_i,
	input  logic                       txwrite_i,
	input  logic                       tick_i,
	input  logic                       char_done_i,
	input  logic                       credit_avail_i,
	input  logic                       fct_pending_i,
	output logic                       load_o,
	output spw_tx_pkg::spw_char_kind_e char_kind_o,
	output logic                       nchar_sent_o,
	output logic                       fct_sent_o,
	output logic                       ready_data_o,
	output logic                       ready_timecode_o
);

	localparam int FCT_CNT_W = (INIT_FCT_COUNT < 1) ? 1 : $clog2(INIT_FCT_COUNT + 1);

	spw_tx_pkg::spw_link_state_e state_q;
	spw_tx_pkg::spw_link_state_e state_d;
	logic [FCT_CNT_W-1:0]        init_cnt_q;
	logic [FCT_CNT_W-1:0]        init_cnt_d;
	logic                        init_done;

	assign init_done = (init_cnt_q == FCT_CNT_W'(INIT_FCT_COUNT));

	//--------------------------------------------------------------------------
	// Next character selection
	//--------------------------------------------------------------------------
	always_comb
	begin
		state_d          = state_q;
		init_cnt_d       = init_cnt_q;
		load_o           = 1'b0;
		char_kind_o      = spw_tx_pkg::CHAR_NULL;
		nchar_sent_o     = 1'b0;
		fct_sent_o       = 1'b0;
		ready_data_o     = 1'b0;
		ready_timecode_o = 1'b0;

		case (state_q)
			spw_tx_pkg::LINK_START:
			begin
				// Line is idle, first NULL goes out right away
				if (send_null_tx_i)
				begin
					load_o  = 1'b1;
					state_d = spw_tx_pkg::LINK_NULL;
				end
			end
			spw_tx_pkg::LINK_NULL:
			begin
				if (char_done_i)
				begin
					load_o = 1'b1;
					if (send_fct_tx_i)
					begin
						state_d = spw_tx_pkg::LINK_NULL_FCT;
					end
				end
			end
			spw_tx_pkg::LINK_NULL_FCT:
			begin
				if (char_done_i)
				begin
					load_o = 1'b1;
					if (!init_done && send_fct_tx_i)
					begin
						char_kind_o = spw_tx_pkg::CHAR_FCT;
						init_cnt_d  = init_cnt_q + 1'b1;
					end
					else if (init_done && credit_avail_i)
					begin
						state_d = spw_tx_pkg::LINK_RUN;
					end
				end
			end
			spw_tx_pkg::LINK_RUN:
			begin
				// Time code first, then owed FCT, then N-char, else NULL
				if (char_done_i)
				begin
					load_o = 1'b1;
					if (tick_i)
					begin
						char_kind_o      = spw_tx_pkg::CHAR_TIMECODE;
						ready_timecode_o = 1'b1;
					end
					else if (fct_pending_i)
					begin
						char_kind_o = spw_tx_pkg::CHAR_FCT;
						fct_sent_o  = 1'b1;
					end
					else if (txwrite_i && credit_avail_i)
					begin
						char_kind_o  = spw_tx_pkg::CHAR_NCHAR;
						nchar_sent_o = 1'b1;
						ready_data_o = 1'b1;
					end
				end
			end
			default:
			begin
				state_d = spw_tx_pkg::LINK_START;
			end
		endcase
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			state_q    <= spw_tx_pkg::LINK_START;
			init_cnt_q <= '0;
		end
		else
		begin
			state_q    <= state_d;
			init_cnt_q <= init_cnt_d;
		end
	end

	// Loads land on serializer boundaries and the first one on an idle line
	a_load_on_boundary: assert property (
		@(posedge pclk_tx) disable iff (!enable_tx)
		load_o |-> (char_done_i != (state_q == spw_tx_pkg::LINK_START))
	);

endmodule

// ==== spw_flow_credit.sv ====
// Flow-control counters of the transmitter.
// Tracks the N-char credit granted by the peer (eight per received FCT)
// and the number of FCTs we still owe the peer for freed receive space.
// All inputs are single-cycle pulses on pclk_tx.

module spw_flow_credit (
	input  logic pclk_tx,
	input  logic enable_tx,
	input  logic got_fct_i,
	input  logic fct_req_i,
	input  logic nchar_sent_i,
	input  logic fct_sent_i,
	output logic credit_avail_o,
	output logic fct_pending_o
);

	spw_tx_pkg::spw_credit_t  credit_q;
	spw_tx_pkg::spw_fct_cnt_t fct_owed_q;

	//--------------------------------------------------------------------------
	// Credit for the peer's receive buffer
	//--------------------------------------------------------------------------
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			credit_q <= '0;
		end
		else
		begin
			case ({got_fct_i, nchar_sent_i})
				2'b10:   credit_q <= credit_q + spw_tx_pkg::CREDIT_PER_FCT;
				2'b01:   credit_q <= credit_q - 6'd1;
				// Grant and send in the same cycle
				2'b11:   credit_q <= credit_q + spw_tx_pkg::CREDIT_PER_FCT - 6'd1;
				default: credit_q <= credit_q;
			endcase
		end
	end

	assign credit_avail_o = (credit_q != '0);

	//--------------------------------------------------------------------------
	// FCTs owed for our own receive buffer
	//--------------------------------------------------------------------------
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			fct_owed_q <= '0;
		end
		else
		begin
			case ({fct_req_i, fct_sent_i})
				2'b10:   fct_owed_q <= fct_owed_q + 3'd1;
				2'b01:   fct_owed_q <= fct_owed_q - 3'd1;
				default: fct_owed_q <= fct_owed_q;
			endcase
		end
	end

	assign fct_pending_o = (fct_owed_q != '0);

	// Peer must never grant more than its buffer holds
	a_credit_max: assert property (
		@(posedge pclk_tx) disable iff (!enable_tx)
		credit_q <= spw_tx_pkg::CREDIT_MAX
	);

	// FSM only sends an N-char while credit is left
	a_no_send_without_credit: assert property (
		@(posedge pclk_tx) disable iff (!enable_tx)
		nchar_sent_i |-> (credit_q != '0)
	);

endmodule

// ==== spw_char_serializer.sv ====
// Character serializer with data-strobe encoding.
// On load_i it builds one character (parity, flag, payload) into a shift
// register and sends it LSB first, one bit per cycle. char_done_o marks
// the last bit so the next load follows without a gap. The strobe toggles
// whenever the data bit repeats, so exactly one line changes per bit.

module spw_char_serializer (
	input  logic                       pclk_tx,
	input  logic                       enable_tx,
	input  logic                       load_i,
	input  spw_tx_pkg::spw_char_kind_e char_kind_i,
	input  spw_tx_pkg::spw_nchar_t     data_i,
	input  spw_tx_pkg::spw_timecode_t  timecode_i,
	output logic                       char_done_o,
	output logic                       tx_dout_o,
	output logic                       tx_sout_o
);

	logic [spw_tx_pkg::LEN_TIMECODE-1:0] word_d;
	logic [spw_tx_pkg::LEN_TIMECODE-2:0] shift_q;
	logic [3:0]                          len_d;
	logic [3:0]                          cnt_q;
	logic                                flag_d;
	logic                                pay_par_d;
	logic                                prev_par_q;
	logic [1:0]                          eop_eep_code;
	logic                                busy_q;
	logic                                shift_en;
	logic                                next_bit;

	// Low two bits of a control N-char pick EOP or EEP
	assign eop_eep_code = (data_i[1:0] == 2'b01) ? spw_tx_pkg::CTRL_EEP
	                                             : spw_tx_pkg::CTRL_EOP;

	//--------------------------------------------------------------------------
	// Character build, bit 0 is sent first
	//--------------------------------------------------------------------------
	always_comb
	begin
		word_d    = '0;
		len_d     = spw_tx_pkg::LEN_NULL;
		flag_d    = 1'b1;
		pay_par_d = ^spw_tx_pkg::CTRL_FCT;

		case (char_kind_i)
			spw_tx_pkg::CHAR_FCT:
			begin
				word_d[3:2] = spw_tx_pkg::CTRL_FCT;
				len_d       = spw_tx_pkg::LEN_CTRL;
				pay_par_d   = ^spw_tx_pkg::CTRL_FCT;
			end
			spw_tx_pkg::CHAR_NCHAR:
			begin
				flag_d = data_i[8];
				if (data_i[8])
				begin
					word_d[3:2] = eop_eep_code;
					len_d       = spw_tx_pkg::LEN_CTRL;
					pay_par_d   = ^eop_eep_code;
				end
				else
				begin
					word_d[9:2] = data_i[7:0];
					len_d       = spw_tx_pkg::LEN_DATA;
					pay_par_d   = ^data_i[7:0];
				end
			end
			spw_tx_pkg::CHAR_TIMECODE:
			begin
				// ESC, then a data-form character carrying the time
				word_d[3:2]  = spw_tx_pkg::CTRL_ESC;
				word_d[4]    = ~(^spw_tx_pkg::CTRL_ESC);
				word_d[5]    = 1'b0;
				word_d[13:6] = timecode_i;
				len_d        = spw_tx_pkg::LEN_TIMECODE;
				pay_par_d    = ^timecode_i;
			end
			default:
			begin
				// NULL is ESC followed by FCT
				word_d[3:2] = spw_tx_pkg::CTRL_ESC;
				word_d[4]   = ~((^spw_tx_pkg::CTRL_ESC) ^ 1'b1);
				word_d[5]   = 1'b1;
				word_d[7:6] = spw_tx_pkg::CTRL_FCT;
				len_d       = spw_tx_pkg::LEN_NULL;
				pay_par_d   = ^spw_tx_pkg::CTRL_FCT;
			end
		endcase

		// Parity covers the previous payload and this flag
		word_d[1] = flag_d;
		word_d[0] = ~(prev_par_q ^ flag_d);
	end

	assign char_done_o = busy_q && (cnt_q == 4'd0);
	assign shift_en    = load_i || (busy_q && (cnt_q != 4'd0));
	assign next_bit    = load_i ? word_d[0] : shift_q[0];

	//--------------------------------------------------------------------------
	// Bit counter, parity history and DS line
	//--------------------------------------------------------------------------
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			busy_q     <= 1'b0;
			cnt_q      <= 4'd0;
			prev_par_q <= 1'b0;
			tx_dout_o  <= 1'b0;
			tx_sout_o  <= 1'b0;
		end
		else
		begin
			if (load_i)
			begin
				busy_q     <= 1'b1;
				cnt_q      <= len_d - 4'd1;
				prev_par_q <= pay_par_d;
			end
			else if (char_done_o)
			begin
				busy_q <= 1'b0;
			end
			else if (busy_q)
			begin
				cnt_q <= cnt_q - 4'd1;
			end

			if (shift_en)
			begin
				tx_dout_o <= next_bit;
				// Strobe toggles when data repeats
				if (next_bit == tx_dout_o)
				begin
					tx_sout_o <= ~tx_sout_o;
				end
			end
		end
	end

	// Payload shift register
	always_ff @(posedge pclk_tx)
	begin
		if (load_i)
		begin
			shift_q <= word_d[spw_tx_pkg::LEN_TIMECODE-1:1];
		end
		else if (shift_en)
		begin
			shift_q <= {1'b0, shift_q[spw_tx_pkg::LEN_TIMECODE-2:1]};
		end
	end

	// Every cycle of a busy line moves exactly one wire, with no gap
	a_ds_one_change: assert property (
		@(posedge pclk_tx) disable iff (!enable_tx)
		busy_q |=> ($changed(tx_dout_o) != $changed(tx_sout_o))
	);

endmodule

// ==== spw_tx_pkg.sv ====
// Shared definitions for the SpaceWire link transmitter.
// Holds the character widths, control codes, character lengths and the
// state types. Modules refer to these by scoped name.

package spw_tx_pkg;

	// N-char word, bit 8 is the control flag
	typedef logic [8:0] spw_nchar_t;

	typedef logic [7:0] spw_timecode_t;

	// Credit granted by the peer, 0 to 56
	typedef logic [5:0] spw_credit_t;

	// FCTs still owed to the peer
	typedef logic [2:0] spw_fct_cnt_t;

	typedef enum logic [1:0] {
		LINK_START,
		LINK_NULL,
		LINK_NULL_FCT,
		LINK_RUN
	} spw_link_state_e;

	typedef enum logic [2:0] {
		CHAR_NULL,
		CHAR_FCT,
		CHAR_NCHAR,
		CHAR_TIMECODE
	} spw_char_kind_e;

	//--------------------------------------------------------------------------
	// Control codes, sent after the flag bit
	//--------------------------------------------------------------------------
	localparam logic [1:0] CTRL_FCT = 2'b00;
	localparam logic [1:0] CTRL_EOP = 2'b01;
	localparam logic [1:0] CTRL_EEP = 2'b10;
	localparam logic [1:0] CTRL_ESC = 2'b11;

	// Character lengths in bits, parity included
	localparam logic [3:0] LEN_NULL     = 4'd8;
	localparam logic [3:0] LEN_CTRL     = 4'd4;
	localparam logic [3:0] LEN_DATA     = 4'd10;
	localparam logic [3:0] LEN_TIMECODE = 4'd14;

	// One received FCT opens eight N-char slots at the peer
	localparam spw_credit_t CREDIT_PER_FCT = 6'd8;
	localparam spw_credit_t CREDIT_MAX     = 6'd56;

endpackage
